//--- Bender.yml
package:
  name: rv_decoder

sources:
  - files:
      - common/rv_isa_pkg.sv
      - common/rv_ctrl_pkg.sv
      - design/control_decode.sv
      - design/imm_gen.sv
      - design/decode_register.sv
      - design/rv_decoder.sv
  - target: simulation
    files:
      - sim/decode_checker.sv
      - sim/tb_rv_decoder.sv

//--- common/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB,
		ALU_INC,  // Return address, PC plus 4
		ALU_SEQ,
		ALU_SNE,
		ALU_SLT,
		ALU_SGE,
		ALU_SLTU,
		ALU_SGEU,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_op_e;

	// Nine members do not fit in three bits
	typedef enum logic [3:0] {
		MEM_NONE = 4'd0,
		MEM_LB,
		MEM_LH,
		MEM_LW,
		MEM_LBU,
		MEM_LHU,
		MEM_SB,
		MEM_SH,
		MEM_SW
	} mem_op_e;

	typedef enum logic [1:0] {
		UMULL,   // Low word, same for any signedness
		SMULH,
		SUMULH,
		UMULH
	} mul_op_e;

	typedef enum logic [1:0] {
		SDIV,
		UDIV,
		SREM,
		UREM
	} div_op_e;

	typedef enum logic [2:0] {
		SEL_ALU = 3'd0,
		SEL_MEM,
		SEL_MUL,
		SEL_DIV
	} wb_src_e;

endpackage

//--- common/rv_isa_pkg.sv
package rv_isa_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int OPCODE_W   = 7;
	localparam int FUNCT3_W   = 3;
	localparam int FUNCT7_W   = 7;

	typedef enum logic [OPCODE_W-1:0] {
		LUI      = 7'b0110111,
		AUIPC    = 7'b0010111,
		JAL      = 7'b1101111,
		JALR     = 7'b1100111,
		BRANCH   = 7'b1100011,
		LOAD     = 7'b0000011,
		STORE    = 7'b0100011,
		OP_IMM   = 7'b0010011,
		OP       = 7'b0110011,
		MISC_MEM = 7'b0001111,
		SYSTEM   = 7'b1110011
	} opcode_e;

	// Branch compares
	localparam logic [FUNCT3_W-1:0] F3_BEQ  = 3'b000;
	localparam logic [FUNCT3_W-1:0] F3_BNE  = 3'b001;
	localparam logic [FUNCT3_W-1:0] F3_BLT  = 3'b100;
	localparam logic [FUNCT3_W-1:0] F3_BGE  = 3'b101;
	localparam logic [FUNCT3_W-1:0] F3_BLTU = 3'b110;
	localparam logic [FUNCT3_W-1:0] F3_BGEU = 3'b111;

	localparam logic [FUNCT3_W-1:0] F3_LB  = 3'b000;
	localparam logic [FUNCT3_W-1:0] F3_LH  = 3'b001;
	localparam logic [FUNCT3_W-1:0] F3_LW  = 3'b010;
	localparam logic [FUNCT3_W-1:0] F3_LBU = 3'b100;
	localparam logic [FUNCT3_W-1:0] F3_LHU = 3'b101;
	localparam logic [FUNCT3_W-1:0] F3_SB  = 3'b000;
	localparam logic [FUNCT3_W-1:0] F3_SH  = 3'b001;
	localparam logic [FUNCT3_W-1:0] F3_SW  = 3'b010;

	// Shared by OP_IMM and OP, the shifts and ADD/SUB are split by funct7
	localparam logic [FUNCT3_W-1:0] F3_ADD  = 3'b000;
	localparam logic [FUNCT3_W-1:0] F3_SLL  = 3'b001;
	localparam logic [FUNCT3_W-1:0] F3_SLT  = 3'b010;
	localparam logic [FUNCT3_W-1:0] F3_SLTU = 3'b011;
	localparam logic [FUNCT3_W-1:0] F3_XOR  = 3'b100;
	localparam logic [FUNCT3_W-1:0] F3_SRL  = 3'b101;
	localparam logic [FUNCT3_W-1:0] F3_OR   = 3'b110;
	localparam logic [FUNCT3_W-1:0] F3_AND  = 3'b111;

	localparam logic [FUNCT3_W-1:0] F3_MUL    = 3'b000;
	localparam logic [FUNCT3_W-1:0] F3_MULH   = 3'b001;
	localparam logic [FUNCT3_W-1:0] F3_MULHSU = 3'b010;
	localparam logic [FUNCT3_W-1:0] F3_MULHU  = 3'b011;
	localparam logic [FUNCT3_W-1:0] F3_DIV    = 3'b100;
	localparam logic [FUNCT3_W-1:0] F3_DIVU   = 3'b101;
	localparam logic [FUNCT3_W-1:0] F3_REM    = 3'b110;
	localparam logic [FUNCT3_W-1:0] F3_REMU   = 3'b111;

	localparam logic [FUNCT3_W-1:0] F3_JALR  = 3'b000;
	localparam logic [FUNCT3_W-1:0] F3_FENCE = 3'b000;

	localparam logic [FUNCT7_W-1:0] FUNCT7_BASE   = 7'b0000000;
	localparam logic [FUNCT7_W-1:0] FUNCT7_ALT    = 7'b0100000;
	localparam logic [FUNCT7_W-1:0] FUNCT7_MULDIV = 7'b0000001;

	localparam logic [XLEN-1:0] INST_ECALL  = 32'h0000_0073;
	localparam logic [XLEN-1:0] INST_EBREAK = 32'h0010_0073;

	typedef enum logic [2:0] {
		IMM_NONE,
		IMM_I,
		IMM_S,
		IMM_B,
		IMM_U,
		IMM_J
	} imm_fmt_e;

endpackage

//--- design/control_decode.sv
`timescale 1ns/1ps

module control_decode import rv_isa_pkg::*, rv_ctrl_pkg::*; #(
	parameter bit HAS_MEXT = 1'b1
) (
	input  logic [XLEN-1:0]       inst,

	output imm_fmt_e              imm_fmt,
	output logic [REG_ADDR_W-1:0] rs1_addr,
	output logic [REG_ADDR_W-1:0] rs2_addr,
	output logic [REG_ADDR_W-1:0] rd_addr,
	output logic                  rs1_access,
	output logic                  rs2_access,
	output logic                  rd_access,
	output logic                  sel_pc,
	output logic                  sel_imm,
	output wb_src_e               wb_src,
	output alu_op_e               alu_op,
	output mem_op_e               mem_op,
	output mul_op_e               mul_op,
	output div_op_e               div_op,
	output logic                  jump_ena,
	output logic                  jump_ind,
	output logic                  jump_alw,
	output logic                  illegal_inst
);

	opcode_e             opcode;
	logic [FUNCT3_W-1:0] funct3;
	logic [FUNCT7_W-1:0] funct7;

	assign opcode   = opcode_e'(inst[OPCODE_W-1:0]);
	assign funct3   = inst[14:12];
	assign funct7   = inst[31:25];
	assign rs1_addr = inst[19:15];
	assign rs2_addr = inst[24:20];
	assign rd_addr  = inst[11:7];

	// The variant is resolved first, the common fields only once the encoding proved legal
	always_comb begin
		imm_fmt      = IMM_NONE;
		rs1_access   = 1'b0;
		rs2_access   = 1'b0;
		rd_access    = 1'b0;
		sel_pc       = 1'b0;
		sel_imm      = 1'b0;
		wb_src       = SEL_ALU;
		alu_op       = ALU_ADD;
		mem_op       = MEM_NONE;
		mul_op       = UMULL;
		div_op       = SDIV;
		jump_ena     = 1'b0;
		jump_ind     = 1'b0;
		jump_alw     = 1'b0;
		illegal_inst = 1'b0;

		case (opcode)
			LUI, AUIPC: begin
				imm_fmt   = IMM_U;
				rd_access = 1'b1;
				sel_imm   = 1'b1;
				sel_pc    = (opcode == AUIPC);
			end
			JAL: begin
				imm_fmt   = IMM_J;
				rd_access = 1'b1;
				sel_pc    = 1'b1;
				alu_op    = ALU_INC;
				jump_ena  = 1'b1;
				jump_alw  = 1'b1;
			end
			JALR: begin
				if (funct3 == F3_JALR) begin
					imm_fmt    = IMM_I;
					rs1_access = 1'b1;
					rd_access  = 1'b1;
					sel_pc     = 1'b1;
					alu_op     = ALU_INC;
					jump_ena   = 1'b1;
					jump_ind   = 1'b1;
					jump_alw   = 1'b1;
				end else begin
					illegal_inst = 1'b1;
				end
			end
			BRANCH: begin
				case (funct3)
					F3_BEQ:  alu_op = ALU_SEQ;
					F3_BNE:  alu_op = ALU_SNE;
					F3_BLT:  alu_op = ALU_SLT;
					F3_BGE:  alu_op = ALU_SGE;
					F3_BLTU: alu_op = ALU_SLTU;
					F3_BGEU: alu_op = ALU_SGEU;
					default: illegal_inst = 1'b1;
				endcase
				if (!illegal_inst) begin
					imm_fmt    = IMM_B;
					rs1_access = 1'b1;
					rs2_access = 1'b1;
					jump_ena   = 1'b1;
				end else begin
					alu_op = ALU_ADD;
				end
			end
			LOAD: begin
				case (funct3)
					F3_LB:   mem_op = MEM_LB;
					F3_LH:   mem_op = MEM_LH;
					F3_LW:   mem_op = MEM_LW;
					F3_LBU:  mem_op = MEM_LBU;
					F3_LHU:  mem_op = MEM_LHU;
					default: illegal_inst = 1'b1;
				endcase
				if (!illegal_inst) begin
					imm_fmt    = IMM_I;
					rs1_access = 1'b1;
					rd_access  = 1'b1;
					sel_imm    = 1'b1;
					wb_src     = SEL_MEM;
				end
			end
			STORE: begin
				case (funct3)
					F3_SB:   mem_op = MEM_SB;
					F3_SH:   mem_op = MEM_SH;
					F3_SW:   mem_op = MEM_SW;
					default: illegal_inst = 1'b1;
				endcase
				if (!illegal_inst) begin
					imm_fmt    = IMM_S;
					rs1_access = 1'b1;
					rs2_access = 1'b1;
					sel_imm    = 1'b1;
					wb_src     = SEL_MEM;  // Stores also select the memory path while rd_access stays low
				end
			end
			OP_IMM: begin
				case (funct3)
					F3_ADD:  alu_op = ALU_ADD;
					F3_SLT:  alu_op = ALU_SLT;
					F3_SLTU: alu_op = ALU_SLTU;
					F3_XOR:  alu_op = ALU_XOR;
					F3_OR:   alu_op = ALU_OR;
					F3_AND:  alu_op = ALU_AND;
					F3_SLL:  begin
						if (funct7 == FUNCT7_BASE) alu_op = ALU_SLL;
						else illegal_inst = 1'b1;
					end
					default: begin
						if (funct7 == FUNCT7_BASE) alu_op = ALU_SRL;
						else if (funct7 == FUNCT7_ALT) alu_op = ALU_SRA;
						else illegal_inst = 1'b1;
					end
				endcase
				if (!illegal_inst) begin
					imm_fmt    = IMM_I;
					rs1_access = 1'b1;
					rd_access  = 1'b1;
					sel_imm    = 1'b1;
				end
			end
			OP: begin
				case (funct7)
					FUNCT7_BASE: begin
						case (funct3)
							F3_ADD:  alu_op = ALU_ADD;
							F3_SLL:  alu_op = ALU_SLL;
							F3_SLT:  alu_op = ALU_SLT;
							F3_SLTU: alu_op = ALU_SLTU;
							F3_XOR:  alu_op = ALU_XOR;
							F3_SRL:  alu_op = ALU_SRL;
							F3_OR:   alu_op = ALU_OR;
							default: alu_op = ALU_AND;
						endcase
					end
					FUNCT7_ALT: begin
						if (funct3 == F3_ADD) alu_op = ALU_SUB;
						else if (funct3 == F3_SRL) alu_op = ALU_SRA;
						else illegal_inst = 1'b1;
					end
					FUNCT7_MULDIV: begin
						if (!HAS_MEXT) begin
							illegal_inst = 1'b1;
						end else if (funct3[2]) begin
							wb_src = SEL_DIV;
							div_op = div_op_e'(funct3[1:0]);  // DIV, DIVU, REM, REMU in funct3 order
						end else begin
							wb_src = SEL_MUL;
							mul_op = mul_op_e'(funct3[1:0]);
						end
					end
					default: illegal_inst = 1'b1;
				endcase
				if (!illegal_inst) begin
					rs1_access = 1'b1;
					rs2_access = 1'b1;
					rd_access  = 1'b1;
				end
			end
			MISC_MEM: illegal_inst = (funct3 != F3_FENCE);
			SYSTEM:   illegal_inst = (inst != INST_ECALL) && (inst != INST_EBREAK);
			default:  illegal_inst = 1'b1;
		endcase
	end

endmodule

//--- design/decode_register.sv
`timescale 1ns/1ps

module decode_register import rv_isa_pkg::*, rv_ctrl_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  inst_valid,

	input  logic [XLEN-1:0]       immediate_d,
	input  logic [REG_ADDR_W-1:0] rs1_addr_d,
	input  logic [REG_ADDR_W-1:0] rs2_addr_d,
	input  logic [REG_ADDR_W-1:0] rd_addr_d,
	input  logic                  rs1_access_d,
	input  logic                  rs2_access_d,
	input  logic                  rd_access_d,
	input  logic                  sel_pc_d,
	input  logic                  sel_imm_d,
	input  wb_src_e               wb_src_d,
	input  alu_op_e               alu_op_d,
	input  mem_op_e               mem_op_d,
	input  mul_op_e               mul_op_d,
	input  div_op_e               div_op_d,
	input  logic                  jump_ena_d,
	input  logic                  jump_ind_d,
	input  logic                  jump_alw_d,
	input  logic                  illegal_inst_d,

	output logic [XLEN-1:0]       immediate,
	output logic [REG_ADDR_W-1:0] rs1_addr,
	output logic [REG_ADDR_W-1:0] rs2_addr,
	output logic [REG_ADDR_W-1:0] rd_addr,
	output logic                  rs1_access,
	output logic                  rs2_access,
	output logic                  rd_access,
	output logic                  sel_pc,
	output logic                  sel_imm,
	output wb_src_e               wb_src,
	output alu_op_e               alu_op,
	output mem_op_e               mem_op,
	output mul_op_e               mul_op,
	output div_op_e               div_op,
	output logic                  jump_ena,
	output logic                  jump_ind,
	output logic                  jump_alw,
	output logic                  illegal_inst,
	output logic                  dec_valid
);

	always_ff @(posedge clk) begin
		if (rst) begin
			immediate    <= '0;
			rs1_addr     <= '0;
			rs2_addr     <= '0;
			rd_addr      <= '0;
			rs1_access   <= 1'b0;
			rs2_access   <= 1'b0;
			rd_access    <= 1'b0;
			sel_pc       <= 1'b0;
			sel_imm      <= 1'b0;
			wb_src       <= SEL_ALU;
			alu_op       <= ALU_ADD;
			mem_op       <= MEM_NONE;
			mul_op       <= UMULL;
			div_op       <= SDIV;
			jump_ena     <= 1'b0;
			jump_ind     <= 1'b0;
			jump_alw     <= 1'b0;
			illegal_inst <= 1'b0;
			dec_valid    <= 1'b0;
		end else begin
			// Fields load every cycle, only the valid bit follows inst_valid
			immediate    <= immediate_d;
			rs1_addr     <= rs1_addr_d;
			rs2_addr     <= rs2_addr_d;
			rd_addr      <= rd_addr_d;
			rs1_access   <= rs1_access_d;
			rs2_access   <= rs2_access_d;
			rd_access    <= rd_access_d;
			sel_pc       <= sel_pc_d;
			sel_imm      <= sel_imm_d;
			wb_src       <= wb_src_d;
			alu_op       <= alu_op_d;
			mem_op       <= mem_op_d;
			mul_op       <= mul_op_d;
			div_op       <= div_op_d;
			jump_ena     <= jump_ena_d;
			jump_ind     <= jump_ind_d;
			jump_alw     <= jump_alw_d;
			illegal_inst <= illegal_inst_d;
			dec_valid    <= inst_valid;
		end
	end

	// An indirect jump is always taken
	assert property (@(posedge clk) disable iff (rst) jump_ind |-> jump_alw)
		else $error("jump_ind set without jump_alw");

	assert property (@(posedge clk) disable iff (rst) jump_alw |-> rd_access)
		else $error("Unconditional jump does not write a link register");

	assert property (@(posedge clk) disable iff (rst)
		(mem_op != MEM_NONE) == (wb_src == SEL_MEM))
		else $error("mem_op and wb_src disagree on a memory access");

	assert property (@(posedge clk) rst |=> !dec_valid)
		else $error("dec_valid high right after reset");

endmodule

//--- design/imm_gen.sv
`timescale 1ns/1ps

module imm_gen import rv_isa_pkg::*; (
	input  logic [XLEN-1:0] inst,
	input  imm_fmt_e        imm_fmt,
	output logic [XLEN-1:0] immediate
);

	logic sign;

	assign sign = inst[31];

	always_comb begin
		case (imm_fmt)
			IMM_I:   immediate = {{(XLEN-11){sign}}, inst[30:20]};
			IMM_S:   immediate = {{(XLEN-11){sign}}, inst[30:25], inst[11:7]};
			// Branch and jump offsets count in halfwords, bit 0 is always zero
			IMM_B:   immediate = {{(XLEN-12){sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			IMM_U:   immediate = {inst[31:12], 12'h000};
			IMM_J:   immediate = {{(XLEN-20){sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			default: immediate = '0;
		endcase
	end

endmodule

//--- design/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder import rv_isa_pkg::*, rv_ctrl_pkg::*; #(
	parameter bit HAS_MEXT = 1'b1
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [XLEN-1:0]       inst,
	input  logic                  inst_valid,

	output logic [XLEN-1:0]       immediate,
	output logic [REG_ADDR_W-1:0] rs1_addr,
	output logic [REG_ADDR_W-1:0] rs2_addr,
	output logic [REG_ADDR_W-1:0] rd_addr,
	output logic                  rs1_access,
	output logic                  rs2_access,
	output logic                  rd_access,
	output logic                  sel_pc,
	output logic                  sel_imm,
	output wb_src_e               wb_src,
	output alu_op_e               alu_op,
	output mem_op_e               mem_op,
	output mul_op_e               mul_op,
	output div_op_e               div_op,
	output logic                  jump_ena,
	output logic                  jump_ind,
	output logic                  jump_alw,
	output logic                  illegal_inst,
	output logic                  dec_valid
);

	imm_fmt_e              imm_fmt;
	logic [XLEN-1:0]       immediate_d;
	logic [REG_ADDR_W-1:0] rs1_addr_d;
	logic [REG_ADDR_W-1:0] rs2_addr_d;
	logic [REG_ADDR_W-1:0] rd_addr_d;
	logic                  rs1_access_d;
	logic                  rs2_access_d;
	logic                  rd_access_d;
	logic                  sel_pc_d;
	logic                  sel_imm_d;
	wb_src_e               wb_src_d;
	alu_op_e               alu_op_d;
	mem_op_e               mem_op_d;
	mul_op_e               mul_op_d;
	div_op_e               div_op_d;
	logic                  jump_ena_d;
	logic                  jump_ind_d;
	logic                  jump_alw_d;
	logic                  illegal_inst_d;

	control_decode #(
		.HAS_MEXT(HAS_MEXT)
	) u_control_decode (
		.inst        (inst),
		.imm_fmt     (imm_fmt),
		.rs1_addr    (rs1_addr_d),
		.rs2_addr    (rs2_addr_d),
		.rd_addr     (rd_addr_d),
		.rs1_access  (rs1_access_d),
		.rs2_access  (rs2_access_d),
		.rd_access   (rd_access_d),
		.sel_pc      (sel_pc_d),
		.sel_imm     (sel_imm_d),
		.wb_src      (wb_src_d),
		.alu_op      (alu_op_d),
		.mem_op      (mem_op_d),
		.mul_op      (mul_op_d),
		.div_op      (div_op_d),
		.jump_ena    (jump_ena_d),
		.jump_ind    (jump_ind_d),
		.jump_alw    (jump_alw_d),
		.illegal_inst(illegal_inst_d)
	);

	imm_gen u_imm_gen (
		.inst     (inst),
		.imm_fmt  (imm_fmt),
		.immediate(immediate_d)
	);

	// Port names line up one to one with the wires above
	decode_register u_decode_register (.*);

endmodule

//--- rv_decoder.f
common/rv_isa_pkg.sv
common/rv_ctrl_pkg.sv
design/control_decode.sv
design/imm_gen.sv
design/decode_register.sv
design/rv_decoder.sv
sim/decode_checker.sv
sim/tb_rv_decoder.sv

//--- sim/decode_checker.sv
`timescale 1ns/1ps

module decode_checker import rv_isa_pkg::*, rv_ctrl_pkg::*; #(
	parameter bit HAS_MEXT = 1'b1
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [XLEN-1:0]       inst,
	input  logic                  inst_valid,
	input  logic [XLEN-1:0]       immediate,
	input  logic [REG_ADDR_W-1:0] rs1_addr,
	input  logic [REG_ADDR_W-1:0] rs2_addr,
	input  logic [REG_ADDR_W-1:0] rd_addr,
	input  logic                  rs1_access,
	input  logic                  rs2_access,
	input  logic                  rd_access,
	input  logic                  sel_pc,
	input  logic                  sel_imm,
	input  wb_src_e               wb_src,
	input  alu_op_e               alu_op,
	input  mem_op_e               mem_op,
	input  mul_op_e               mul_op,
	input  div_op_e               div_op,
	input  logic                  jump_ena,
	input  logic                  jump_ind,
	input  logic                  jump_alw,
	input  logic                  illegal_inst,
	input  logic                  dec_valid,
	output int                    error_count,
	output int                    check_count
);

	int              errors = 0;
	int              checks = 0;
	logic            started = 1'b0;
	logic            sampled_rst;
	logic            sampled_valid;
	logic [XLEN-1:0] sampled_inst;
	string           test_name;
	imm_fmt_e        exp_fmt;
	logic [XLEN-1:0] exp_imm;
	logic [2:0]      exp_access;  // rs1, rs2, rd
	logic            exp_sel_pc;
	logic            exp_sel_imm;
	wb_src_e         exp_wb_src;
	alu_op_e         exp_alu_op;
	mem_op_e         exp_mem_op;
	mul_op_e         exp_mul_op;
	div_op_e         exp_div_op;
	logic [2:0]      exp_jump;    // ena, ind, alw
	logic            exp_illegal;

	assign error_count = errors;
	assign check_count = checks;

	function automatic logic [XLEN-1:0] sign_extend(input logic [XLEN-1:0] v, input int bits);
		return $unsigned($signed(v << (XLEN - bits)) >>> (XLEN - bits));
	endfunction

	function automatic logic [XLEN-1:0] form_immediate(input logic [XLEN-1:0] w,
			input imm_fmt_e fmt);
		case (fmt)
			IMM_I: return sign_extend({20'b0, w[31:20]}, 12);
			IMM_S: return sign_extend({20'b0, w[31:25], w[11:7]}, 12);
			IMM_B: return sign_extend({19'b0, w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
			IMM_U: return {w[31:12], 12'b0};
			IMM_J: return sign_extend({11'b0, w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
			default: return '0;
		endcase
	endfunction

	// Base ALU operation for OP and OP_IMM, funct7 handled by the caller
	function automatic alu_op_e alu_for_funct3(input logic [2:0] f3);
		case (f3)
			F3_ADD:  return ALU_ADD;
			F3_SLL:  return ALU_SLL;
			F3_SLT:  return ALU_SLT;
			F3_SLTU: return ALU_SLTU;
			F3_XOR:  return ALU_XOR;
			F3_SRL:  return ALU_SRL;
			F3_OR:   return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	task automatic set_defaults();
		exp_fmt = IMM_NONE;
		exp_access = 3'b000;
		exp_sel_pc = 1'b0;
		exp_sel_imm = 1'b0;
		exp_wb_src = SEL_ALU;
		exp_alu_op = ALU_ADD;
		exp_mem_op = MEM_NONE;
		exp_mul_op = UMULL;
		exp_div_op = SDIV;
		exp_jump = 3'b000;
		exp_illegal = 1'b0;
	endtask

	task automatic predict(input logic [XLEN-1:0] w);
		logic [2:0] f3;
		logic [6:0] f7;
		logic       bad;
		f3 = w[14:12];
		f7 = w[31:25];
		bad = 1'b0;
		set_defaults();
		test_name = "rv32i";
		case (w[6:0])
			LUI, AUIPC: begin
				exp_fmt = IMM_U;
				exp_access = 3'b001;
				exp_sel_imm = 1'b1;
				exp_sel_pc = (w[6:0] == AUIPC);
			end
			JAL, JALR: begin
				bad = (w[6:0] == JALR) && (f3 != F3_JALR);
				exp_fmt = (w[6:0] == JAL) ? IMM_J : IMM_I;
				exp_access = {w[6:0] == JALR, 2'b01};
				exp_sel_pc = 1'b1;
				exp_alu_op = ALU_INC;
				exp_jump = {1'b1, w[6:0] == JALR, 1'b1};
			end
			BRANCH: begin
				exp_fmt = IMM_B;
				exp_access = 3'b110;
				exp_jump = 3'b100;
				case (f3)
					F3_BEQ:  exp_alu_op = ALU_SEQ;
					F3_BNE:  exp_alu_op = ALU_SNE;
					F3_BLT:  exp_alu_op = ALU_SLT;
					F3_BGE:  exp_alu_op = ALU_SGE;
					F3_BLTU: exp_alu_op = ALU_SLTU;
					F3_BGEU: exp_alu_op = ALU_SGEU;
					default: bad = 1'b1;
				endcase
			end
			LOAD, STORE: begin
				exp_fmt = (w[6:0] == LOAD) ? IMM_I : IMM_S;
				exp_access = (w[6:0] == LOAD) ? 3'b101 : 3'b110;
				exp_sel_imm = 1'b1;
				exp_wb_src = SEL_MEM;
				case ({w[6:0] == STORE, f3})
					{1'b0, F3_LB}:  exp_mem_op = MEM_LB;
					{1'b0, F3_LH}:  exp_mem_op = MEM_LH;
					{1'b0, F3_LW}:  exp_mem_op = MEM_LW;
					{1'b0, F3_LBU}: exp_mem_op = MEM_LBU;
					{1'b0, F3_LHU}: exp_mem_op = MEM_LHU;
					{1'b1, F3_SB}:  exp_mem_op = MEM_SB;
					{1'b1, F3_SH}:  exp_mem_op = MEM_SH;
					{1'b1, F3_SW}:  exp_mem_op = MEM_SW;
					default:        bad = 1'b1;
				endcase
			end
			OP_IMM: begin
				exp_fmt = IMM_I;
				exp_access = 3'b101;
				exp_sel_imm = 1'b1;
				exp_alu_op = alu_for_funct3(f3);
				if (f3 == F3_SLL) bad = (f7 != FUNCT7_BASE);
				if (f3 == F3_SRL) begin
					bad = (f7 != FUNCT7_BASE) && (f7 != FUNCT7_ALT);
					if (f7 == FUNCT7_ALT) exp_alu_op = ALU_SRA;
				end
			end
			OP: begin
				exp_access = 3'b111;
				if (f7 == FUNCT7_BASE) begin
					exp_alu_op = alu_for_funct3(f3);
				end else if (f7 == FUNCT7_ALT) begin
					if (f3 == F3_ADD) exp_alu_op = ALU_SUB;
					else if (f3 == F3_SRL) exp_alu_op = ALU_SRA;
					else bad = 1'b1;
				end else if (f7 == FUNCT7_MULDIV && HAS_MEXT) begin
					test_name = "rv32m";
					exp_wb_src = (f3 >= F3_DIV) ? SEL_DIV : SEL_MUL;
					case (f3)
						F3_MUL:    exp_mul_op = UMULL;
						F3_MULH:   exp_mul_op = SMULH;
						F3_MULHSU: exp_mul_op = SUMULH;
						F3_MULHU:  exp_mul_op = UMULH;
						F3_DIV:    exp_div_op = SDIV;
						F3_DIVU:   exp_div_op = UDIV;
						F3_REM:    exp_div_op = SREM;
						default:   exp_div_op = UREM;
					endcase
				end else begin
					bad = 1'b1;
				end
			end
			MISC_MEM: bad = (f3 != F3_FENCE);
			SYSTEM:   bad = (w != INST_ECALL) && (w != INST_EBREAK);
			default:  bad = 1'b1;  // F extension and unknown opcodes
		endcase
		if (bad) begin
			set_defaults();
			exp_illegal = 1'b1;
			test_name = "illegal";
		end
		exp_imm = form_immediate(w, exp_fmt);
	endtask

	task automatic check_value(input string test, input string field,
			input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Error %s %s (inst %08h): expected %h, actual %h",
				test, field, sampled_inst, exp, act);
		end
	endtask

	task automatic check_reset();
		check_value("reset", "flags", '0, {dec_valid, illegal_inst, rs1_access, rs2_access,
			rd_access, jump_ena, jump_ind, jump_alw, sel_pc, sel_imm});
		check_value("reset", "opcodes", {ALU_ADD, MEM_NONE, SEL_ALU}, {alu_op, mem_op, wb_src});
		check_value("reset", "immediate", '0, immediate);
		check_value("reset", "addresses", '0, {rs1_addr, rs2_addr, rd_addr});
	endtask

	task automatic check_decode();
		check_value(test_name, "illegal_inst", exp_illegal, illegal_inst);
		check_value(test_name, "access", exp_access, {rs1_access, rs2_access, rd_access});
		check_value(test_name, "select", {exp_sel_pc, exp_sel_imm}, {sel_pc, sel_imm});
		check_value(test_name, "jump", exp_jump, {jump_ena, jump_ind, jump_alw});
		check_value(test_name, "wb_src", exp_wb_src, wb_src);
		check_value(test_name, "alu_op", exp_alu_op, alu_op);
		check_value(test_name, "mem_op", exp_mem_op, mem_op);
		check_value(test_name, "mul_op", exp_mul_op, mul_op);
		check_value(test_name, "div_op", exp_div_op, div_op);
		check_value(test_name, "immediate", exp_imm, immediate);
		check_value(test_name, "addresses", {sampled_inst[19:15], sampled_inst[24:20],
			sampled_inst[11:7]}, {rs1_addr, rs2_addr, rd_addr});
	endtask

	// Inputs are stable at the rising edge, they change on the falling one
	always @(posedge clk) begin
		started = 1'b1;
		sampled_rst = rst;
		sampled_valid = inst_valid;
		sampled_inst = inst;
		predict(inst);
	end

	always @(negedge clk) begin
		if (started) begin
			if (sampled_rst) begin
				check_reset();
			end else begin
				check_value("valid", "dec_valid", sampled_valid, dec_valid);
				if (sampled_valid) check_decode();
			end
		end
	end

endmodule

//--- sim/tb_rv_decoder.sv
`timescale 1ns/1ps

module tb_rv_decoder import rv_isa_pkg::*, rv_ctrl_pkg::*; ();

	localparam bit HAS_MEXT       = 1'b1;
	localparam int RESET_CYCLES   = 16;
	localparam int N_INST         = 3000;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_INST + 20;

	logic                  clk;
	logic                  rst;
	logic [XLEN-1:0]       inst;
	logic                  inst_valid;
	logic [XLEN-1:0]       immediate;
	logic [REG_ADDR_W-1:0] rs1_addr;
	logic [REG_ADDR_W-1:0] rs2_addr;
	logic [REG_ADDR_W-1:0] rd_addr;
	logic                  rs1_access;
	logic                  rs2_access;
	logic                  rd_access;
	logic                  sel_pc;
	logic                  sel_imm;
	wb_src_e               wb_src;
	alu_op_e               alu_op;
	mem_op_e               mem_op;
	mul_op_e               mul_op;
	div_op_e               div_op;
	logic                  jump_ena;
	logic                  jump_ind;
	logic                  jump_alw;
	logic                  illegal_inst;
	logic                  dec_valid;
	int                    error_count;
	int                    check_count;
	int                    cycle_count = 0;
	logic [31:0]           lcg_state = 32'd91;

	rv_decoder #(.HAS_MEXT(HAS_MEXT)) UUT (.*);

	decode_checker #(.HAS_MEXT(HAS_MEXT)) u_checker (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Two LCG steps per word, only the upper halves are kept
	function automatic logic [31:0] next_rand();
		logic [15:0] hi;
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		hi = lcg_state[31:16];
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {hi, lcg_state[31:16]};
	endfunction

	// Random fields around a chosen instruction class
	function automatic logic [XLEN-1:0] build_template();
		logic [31:0]     r;
		logic [XLEN-1:0] w;
		logic [2:0]      f3;
		r = next_rand();
		w = next_rand();
		f3 = r[10:8];
		case (r[31:27] % 12)
			0: w[6:0] = LUI;
			1: w[6:0] = AUIPC;
			2: w[6:0] = JAL;
			3: w = {w[31:15], F3_JALR, w[11:7], JALR};
			4: begin
				if (f3[2:1] == 2'b01) f3[2] = 1'b1;  // 010 and 011 are no branch
				w = {w[31:15], f3, w[11:7], BRANCH};
			end
			5: begin
				if (f3 == 3'b011) f3[0] = 1'b0;
				else if (f3[2:1] == 2'b11) f3[1] = 1'b0;
				w = {w[31:15], f3, w[11:7], LOAD};
			end
			6: begin
				f3[2] = 1'b0;
				if (f3 == 3'b011) f3[0] = 1'b0;
				w = {w[31:15], f3, w[11:7], STORE};
			end
			7: begin
				w = {w[31:15], f3, w[11:7], OP_IMM};
				if (f3 == F3_SLL || f3 == F3_SRL)
					w[31:25] = (f3 == F3_SRL && r[11]) ? FUNCT7_ALT : FUNCT7_BASE;
			end
			8: begin
				case (r[12:11])
					2'b00: w[31:25] = FUNCT7_BASE;
					2'b01: begin
						w[31:25] = FUNCT7_ALT;
						f3 = r[13] ? F3_SRL : F3_ADD;
					end
					default: w[31:25] = FUNCT7_MULDIV;
				endcase
				w = {w[31:15], f3, w[11:7], OP};
			end
			9: w = {w[31:15], F3_FENCE, w[11:7], MISC_MEM};
			10: w = r[11] ? INST_EBREAK : INST_ECALL;
			default: begin
				// Near misses, F extension opcodes or OP with any funct7
				if (r[11]) begin
					case (r[13:12])
						2'b00: w[6:0] = 7'b0000111;
						2'b01: w[6:0] = 7'b0100111;
						2'b10: w[6:0] = 7'b1010011;
						default: w[6:0] = 7'b1000011;
					endcase
				end else begin
					w[6:0] = OP;
				end
			end
		endcase
		return w;
	endfunction

	initial begin
		logic [31:0] r;
		inst = '0;
		inst_valid = 1'b0;
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < N_INST; i++) begin
			r = next_rand();
			if (r[31:30] == 2'b00) inst = next_rand();  // About a quarter fully random
			else inst = build_template();
			inst_valid = (r[15:0] % 10) < 8;
			@(negedge clk);
		end
		inst_valid = 1'b0;
		repeat (3) @(negedge clk);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("Run timed out after %0d cycles", TIMEOUT_CYCLES);
			$display("Done: errors found");
			$finish;
		end
	end

endmodule
